/* logic/fifo_geom_pkg.sv */
package fifo_geom_pkg;

  ////////////////////////////////////////////////////////////
  // buffer geometry
  ////////////////////////////////////////////////////////////

  // log2 of the number of entries.
  localparam int ADDR_WIDTH = 4;

  // entries held before tready drops.
  localparam int FIFO_DEPTH = 2 ** ADDR_WIDTH;

  // address plus one wrap bit, so full and empty differ.
  localparam int PTR_WIDTH = ADDR_WIDTH + 1;

  ////////////////////////////////////////////////////////////
  // notes
  ////////////////////////////////////////////////////////////

  // Gray full detection compares the top two bits, so the
  // address needs at least two bits.
  // pointers cross clock domains as Gray code only.
  // depth is a power of two so the binary pointer wraps
  // without a compare.

endpackage

/* logic/axis_format_pkg.sv */
package axis_format_pkg;

  ////////////////////////////////////////////////////////////
  // beat format
  ////////////////////////////////////////////////////////////

  // tdata width; tlast and tuser travel beside it.
  localparam int DATA_WIDTH = 8;

  ////////////////////////////////////////////////////////////
  // frame statistics
  ////////////////////////////////////////////////////////////

  localparam int CNT_WIDTH = 16; // frame counters, wrap.
  localparam int LEN_WIDTH = 12; // last frame length, saturates.

  // monitor FSM.
  // idle means no beat of the current frame has been seen,
  // body means at least one non-last beat has passed.
  typedef enum logic {
    FRAME_IDLE = 1'b0,
    FRAME_BODY = 1'b1
  } frame_state_t;

  // a frame is bad when tuser is set on its last beat.
  // a single beat frame goes idle to idle and has length 1.
  // the length includes the tlast beat.

endpackage

/* logic/cdc_reset_bridge.sv */
`timescale 1ns/1ps

module cdc_reset_bridge (
  input  logic input_clk,
  input  logic output_rst_sync3,
  output logic input_rst_sync3
);

  ////////////////////////////////////////////////////////////
  // reset synchronizer into input_clk
  ////////////////////////////////////////////////////////////

  // all stages start in reset so the write side is held from time zero.
  logic rst_sync1 = 1'b1; // metastability stage.
  logic rst_sync2 = 1'b1;
  logic rst_sync3 = 1'b1;

  // once the first stage sees reset the rest are forced high, so the
  // input side enters reset quickly and only leaves it through the chain.
  always_ff @(posedge input_clk) begin
    rst_sync1 <= output_rst_sync3;
    if (rst_sync1) begin
      rst_sync2 <= 1'b1;
      rst_sync3 <= 1'b1;
    end else begin
      rst_sync2 <= rst_sync1;
      rst_sync3 <= rst_sync2;
    end
  end

  assign input_rst_sync3 = rst_sync3;

  ////////////////////////////////////////////////////////////
  // checks
  ////////////////////////////////////////////////////////////

  // a reset seen on the output side always reaches the input side.
  assert property (@(posedge input_clk)
    output_rst_sync3 |-> ##[0:3] input_rst_sync3)
    else $error("input side missed output reset.");

  // release of the input side never precedes release of the source.
  assert property (@(posedge input_clk)
    $fell(input_rst_sync3) |-> !$past(output_rst_sync3, 2))
    else $error("input reset released early.");

endmodule

/* logic/axis_async_fifo.sv */
`timescale 1ns/1ps

module axis_async_fifo #(
  parameter int ADDR_WIDTH = fifo_geom_pkg::ADDR_WIDTH,
  parameter int DATA_WIDTH = axis_format_pkg::DATA_WIDTH
) (
  input  logic                  input_clk,
  input  logic                  input_rst_sync3,
  input  logic                  output_clk,
  input  logic                  output_rst_sync3,

  input  logic [DATA_WIDTH-1:0] input_axis_tdata,
  input  logic                  input_axis_tvalid,
  output logic                  input_axis_tready,
  input  logic                  input_axis_tlast,
  input  logic                  input_axis_tuser,

  output logic [DATA_WIDTH-1:0] output_axis_tdata,
  output logic                  output_axis_tvalid,
  input  logic                  output_axis_tready,
  output logic                  output_axis_tlast,
  output logic                  output_axis_tuser
);

  localparam int DEPTH = 2 ** ADDR_WIDTH;
  localparam int BEAT_WIDTH = DATA_WIDTH + 2; // tlast, tuser, tdata.

  function automatic logic [ADDR_WIDTH:0] bin2gray(input logic [ADDR_WIDTH:0] b);
    return b ^ (b >> 1);
  endfunction

  function automatic logic [ADDR_WIDTH:0] gray2bin(input logic [ADDR_WIDTH:0] g);
    logic [ADDR_WIDTH:0] b;
    b[ADDR_WIDTH] = g[ADDR_WIDTH];
    for (int i = ADDR_WIDTH - 1; i >= 0; i--) begin
      b[i] = b[i+1] ^ g[i];
    end
    return b;
  endfunction

  logic [BEAT_WIDTH-1:0] mem [DEPTH];

  logic [ADDR_WIDTH:0] wr_ptr;
  logic [ADDR_WIDTH:0] wr_ptr_next;
  logic [ADDR_WIDTH:0] wr_ptr_gray;
  logic [ADDR_WIDTH:0] rd_ptr_gray_sync1;
  logic [ADDR_WIDTH:0] rd_ptr_gray_sync2;

  logic [ADDR_WIDTH:0] rd_ptr;
  logic [ADDR_WIDTH:0] rd_ptr_next;
  logic [ADDR_WIDTH:0] rd_ptr_gray;
  logic [ADDR_WIDTH:0] wr_ptr_gray_sync1;
  logic [ADDR_WIDTH:0] wr_ptr_gray_sync2;

  logic [BEAT_WIDTH-1:0] data_out_reg;
  logic                  tvalid_reg;

  logic full;
  logic empty;
  logic write;
  logic read;

  ////////////////////////////////////////////////////////////
  // write side, input_clk
  ////////////////////////////////////////////////////////////

  // full when the pointers differ by exactly one lap.
  assign full = (wr_ptr_gray[ADDR_WIDTH:ADDR_WIDTH-1] ==
                 ~rd_ptr_gray_sync2[ADDR_WIDTH:ADDR_WIDTH-1]) &&
                (wr_ptr_gray[ADDR_WIDTH-2:0] == rd_ptr_gray_sync2[ADDR_WIDTH-2:0]);

  assign input_axis_tready = ~full & ~input_rst_sync3;
  assign write = input_axis_tvalid & input_axis_tready;
  assign wr_ptr_next = wr_ptr + 1'b1;

  always_ff @(posedge input_clk) begin
    if (input_rst_sync3) begin
      wr_ptr      <= '0;
      wr_ptr_gray <= '0;
    end else if (write) begin
      wr_ptr      <= wr_ptr_next;
      wr_ptr_gray <= bin2gray(wr_ptr_next);
    end
  end

  always_ff @(posedge input_clk) begin
    if (write) begin
      mem[wr_ptr[ADDR_WIDTH-1:0]] <= {input_axis_tlast, input_axis_tuser, input_axis_tdata};
    end
  end

  // read pointer into the write domain.
  always_ff @(posedge input_clk) begin
    if (input_rst_sync3) begin
      rd_ptr_gray_sync1 <= '0;
      rd_ptr_gray_sync2 <= '0;
    end else begin
      rd_ptr_gray_sync1 <= rd_ptr_gray;
      rd_ptr_gray_sync2 <= rd_ptr_gray_sync1;
    end
  end

  ////////////////////////////////////////////////////////////
  // read side, output_clk
  ////////////////////////////////////////////////////////////

  assign empty = (rd_ptr_gray == wr_ptr_gray_sync2);
  assign read = (output_axis_tready | ~tvalid_reg) & ~empty; // refill the output stage.
  assign rd_ptr_next = rd_ptr + 1'b1;

  always_ff @(posedge output_clk) begin
    if (output_rst_sync3) begin
      rd_ptr      <= '0;
      rd_ptr_gray <= '0;
      tvalid_reg  <= 1'b0;
    end else begin
      if (read) begin
        rd_ptr      <= rd_ptr_next;
        rd_ptr_gray <= bin2gray(rd_ptr_next);
      end
      if (output_axis_tready | ~tvalid_reg) begin
        tvalid_reg <= ~empty;
      end
    end
  end

  always_ff @(posedge output_clk) begin
    if (read) begin
      data_out_reg <= mem[rd_ptr[ADDR_WIDTH-1:0]];
    end
  end

  // write pointer into the read domain.
  always_ff @(posedge output_clk) begin
    if (output_rst_sync3) begin
      wr_ptr_gray_sync1 <= '0;
      wr_ptr_gray_sync2 <= '0;
    end else begin
      wr_ptr_gray_sync1 <= wr_ptr_gray;
      wr_ptr_gray_sync2 <= wr_ptr_gray_sync1;
    end
  end

  assign {output_axis_tlast, output_axis_tuser, output_axis_tdata} = data_out_reg;
  assign output_axis_tvalid = tvalid_reg;

  ////////////////////////////////////////////////////////////
  // checks
  ////////////////////////////////////////////////////////////

  logic [ADDR_WIDTH:0] wr_fill; // occupancy as the write side sees it.
  logic [ADDR_WIDTH:0] rd_fill; // occupancy as the read side sees it.

  assign wr_fill = wr_ptr - gray2bin(rd_ptr_gray_sync2);
  assign rd_fill = gray2bin(wr_ptr_gray_sync2) - rd_ptr;

  assert property (@(posedge input_clk) disable iff (input_rst_sync3)
    write |-> !wr_fill[ADDR_WIDTH])
    else $error("write into a full buffer.");

  assert property (@(posedge output_clk) disable iff (output_rst_sync3)
    read |-> rd_fill != '0)
    else $error("read from an empty buffer.");

  // a stalled beat must not change.
  assert property (@(posedge output_clk) disable iff (output_rst_sync3)
    output_axis_tvalid && !output_axis_tready |=>
      output_axis_tvalid && $stable(data_out_reg))
    else $error("output beat changed under back-pressure.");

endmodule

/* logic/axis_frame_monitor.sv */
`timescale 1ns/1ps

module axis_frame_monitor (
  input  logic                            output_clk,
  input  logic                            output_rst_sync3,

  input  logic                            output_axis_tvalid,
  input  logic                            output_axis_tready,
  input  logic                            output_axis_tlast,
  input  logic                            output_axis_tuser,

  output logic [axis_format_pkg::CNT_WIDTH-1:0] frame_count,
  output logic [axis_format_pkg::CNT_WIDTH-1:0] bad_frame_count,
  output logic [axis_format_pkg::LEN_WIDTH-1:0] last_frame_len
);

  import axis_format_pkg::*;

  frame_state_t         state;
  logic [LEN_WIDTH-1:0] beat_cnt; // beats of the open frame.
  logic [LEN_WIDTH-1:0] beat_cnt_next;
  logic                 beat_hs;

  assign beat_hs = output_axis_tvalid & output_axis_tready;

  // a new frame restarts at one, an open one counts up and saturates.
  always_comb begin
    if (state == FRAME_IDLE) begin
      beat_cnt_next = LEN_WIDTH'(1);
    end else if (beat_cnt == '1) begin
      beat_cnt_next = beat_cnt;
    end else begin
      beat_cnt_next = beat_cnt + 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////
  // frame tracking
  ////////////////////////////////////////////////////////////

  always_ff @(posedge output_clk) begin
    if (output_rst_sync3) begin
      state           <= FRAME_IDLE;
      beat_cnt        <= '0;
      frame_count     <= '0;
      bad_frame_count <= '0;
      last_frame_len  <= '0;
    end else if (beat_hs) begin
      beat_cnt <= beat_cnt_next;
      if (output_axis_tlast) begin
        state          <= FRAME_IDLE;
        last_frame_len <= beat_cnt_next; // includes the tlast beat.
        frame_count    <= frame_count + 1'b1;
        if (output_axis_tuser) begin
          bad_frame_count <= bad_frame_count + 1'b1;
        end
      end else begin
        state <= FRAME_BODY;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // checks
  ////////////////////////////////////////////////////////////

  // every closed frame leaves the FSM idle and is counted once.
  assert property (@(posedge output_clk) disable iff (output_rst_sync3)
    beat_hs && output_axis_tlast |=>
      state == FRAME_IDLE && frame_count == $past(frame_count) + 1'b1)
    else $error("frame close not recorded.");

endmodule

/* logic/axis_cdc_link.sv */
`timescale 1ns/1ps

module axis_cdc_link (
  input  logic                                   input_clk,
  input  logic                                   output_clk,
  input  logic                                   output_rst_sync3,

  input  logic [axis_format_pkg::DATA_WIDTH-1:0] input_axis_tdata,
  input  logic                                   input_axis_tvalid,
  output logic                                   input_axis_tready,
  input  logic                                   input_axis_tlast,
  input  logic                                   input_axis_tuser,

  output logic [axis_format_pkg::DATA_WIDTH-1:0] output_axis_tdata,
  output logic                                   output_axis_tvalid,
  input  logic                                   output_axis_tready,
  output logic                                   output_axis_tlast,
  output logic                                   output_axis_tuser,

  output logic [axis_format_pkg::CNT_WIDTH-1:0]  frame_count,
  output logic [axis_format_pkg::CNT_WIDTH-1:0]  bad_frame_count,
  output logic [axis_format_pkg::LEN_WIDTH-1:0]  last_frame_len
);

  import fifo_geom_pkg::*;
  import axis_format_pkg::*;

  logic input_rst_sync3; // write side reset.

  cdc_reset_bridge u_reset_bridge (
    .input_clk        (input_clk),
    .output_rst_sync3 (output_rst_sync3),
    .input_rst_sync3  (input_rst_sync3)
  );

  ////////////////////////////////////////////////////////////
  // crossing buffer
  ////////////////////////////////////////////////////////////

  axis_async_fifo #(
    .ADDR_WIDTH (ADDR_WIDTH),
    .DATA_WIDTH (DATA_WIDTH)
  ) u_fifo (
    .input_clk          (input_clk),
    .input_rst_sync3    (input_rst_sync3),
    .output_clk         (output_clk),
    .output_rst_sync3   (output_rst_sync3),
    .input_axis_tdata   (input_axis_tdata),
    .input_axis_tvalid  (input_axis_tvalid),
    .input_axis_tready  (input_axis_tready),
    .input_axis_tlast   (input_axis_tlast),
    .input_axis_tuser   (input_axis_tuser),
    .output_axis_tdata  (output_axis_tdata),
    .output_axis_tvalid (output_axis_tvalid),
    .output_axis_tready (output_axis_tready),
    .output_axis_tlast  (output_axis_tlast),
    .output_axis_tuser  (output_axis_tuser)
  );

  // watches the same wires that leave the top.
  axis_frame_monitor u_frame_monitor (
    .output_clk         (output_clk),
    .output_rst_sync3   (output_rst_sync3),
    .output_axis_tvalid (output_axis_tvalid),
    .output_axis_tready (output_axis_tready),
    .output_axis_tlast  (output_axis_tlast),
    .output_axis_tuser  (output_axis_tuser),
    .frame_count        (frame_count),
    .bad_frame_count    (bad_frame_count),
    .last_frame_len     (last_frame_len)
  );

endmodule

/* tests/axis_cdc_link_tb.sv */
`timescale 1ns/1ps

module axis_cdc_link_tb;

  import fifo_geom_pkg::*;
  import axis_format_pkg::*;

  localparam int NUM_FRAMES    = 24;
  localparam int STALL_CYCLES  = 20;   // input cycles of low tready that mean full.
  localparam int FILL_LIMIT    = 400;
  localparam int ACCEPT_LIMIT  = 400;
  localparam int DRAIN_LIMIT   = 2000;

  logic input_clk = 1'b0;
  logic output_clk = 1'b0;
  logic output_rst_sync3;

  logic [DATA_WIDTH-1:0] input_axis_tdata;
  logic                  input_axis_tvalid;
  logic                  input_axis_tready;
  logic                  input_axis_tlast;
  logic                  input_axis_tuser;

  logic [DATA_WIDTH-1:0] output_axis_tdata;
  logic                  output_axis_tvalid;
  logic                  output_axis_tready;
  logic                  output_axis_tlast;
  logic                  output_axis_tuser;

  logic [CNT_WIDTH-1:0]  frame_count;
  logic [CNT_WIDTH-1:0]  bad_frame_count;
  logic [LEN_WIDTH-1:0]  last_frame_len;

  logic [DATA_WIDTH+1:0] ref_q [$]; // {tlast, tuser, tdata} of accepted beats.
  logic [DATA_WIDTH+1:0] exp_beat = '0;
  int                    exp_count = 0;
  logic [CNT_WIDTH-1:0]  frames_sent = '0;
  logic [CNT_WIDTH-1:0]  bad_sent = '0;
  logic [LEN_WIDTH-1:0]  final_len = '0;
  logic                  final_sent = 1'b0;
  logic                  sink_stall = 1'b1;
  logic                  fill_check = 1'b0;
  logic                  stats_check = 1'b0;
  int                    fill_count = 0;

  always #50 output_clk = ~output_clk;
  always #35 input_clk = ~input_clk;

  axis_cdc_link DUT (.*);

  ////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////

  task automatic report_mismatch(input string msg);
    $display("Fail %0t: %s", $time, msg);
    $display("Test FAILED");
    $fatal(1);
  endtask

  task automatic timeout_abort(input string what);
    $display("timeout at %0t: %s", $time, what);
    $display("Test FAILED");
    $fatal(1);
  endtask

  task automatic present_beat(input logic [DATA_WIDTH-1:0] data, input logic last,
                              input logic user);
    input_axis_tdata  = data;
    input_axis_tlast  = last;
    input_axis_tuser  = user;
    input_axis_tvalid = 1'b1;
  endtask

  task automatic record_beat();
    ref_q.push_back({input_axis_tlast, input_axis_tuser, input_axis_tdata});
  endtask

  // tready only moves on input edges, so the value seen here holds at the next edge.
  task automatic wait_accept();
    int   cycles;
    logic ready;
    cycles = 0;
    ready = 1'b0;
    while (!ready) begin
      ready = input_axis_tready;
      @(posedge input_clk);
      #5;
      cycles++;
      if (!ready && cycles > ACCEPT_LIMIT) begin
        timeout_abort("input beat was never accepted");
      end
    end
    record_beat();
    input_axis_tvalid = 1'b0;
  endtask

  task automatic send_beat(input logic [DATA_WIDTH-1:0] data, input logic last,
                           input logic user);
    present_beat(data, last, user);
    wait_accept();
  endtask

  task automatic send_frame(input int len, input logic bad);
    int gap;
    for (int i = 0; i < len; i++) begin
      gap = $urandom_range(0, 2);
      repeat (gap) begin
        @(posedge input_clk);
        #5;
      end
      send_beat(DATA_WIDTH'($urandom), i == len - 1, (i == len - 1) && bad);
    end
    frames_sent = frames_sent + 1'b1;
    if (bad) begin
      bad_sent = bad_sent + 1'b1;
    end
  endtask

  // keeps tvalid high until tready has stayed low long enough to be full.
  task automatic fill_buffer();
    int   streak;
    int   cycles;
    logic ready;
    streak = 0;
    cycles = 0;
    fill_count = 0;
    present_beat(DATA_WIDTH'($urandom), 1'b0, 1'b0);
    while (streak < STALL_CYCLES) begin
      ready = input_axis_tready;
      @(posedge input_clk);
      #5;
      cycles++;
      if (cycles > FILL_LIMIT) begin
        timeout_abort("input side never stalled while filling");
      end
      if (ready) begin
        record_beat();
        fill_count++;
        streak = 0;
        present_beat(DATA_WIDTH'($urandom), 1'b0, 1'b0);
      end else begin
        streak++;
      end
    end
  endtask

  task automatic wait_drain();
    int cycles;
    cycles = 0;
    while (ref_q.size() != 0) begin
      @(negedge output_clk);
      cycles++;
      if (cycles > DRAIN_LIMIT) begin
        timeout_abort("reference queue did not drain");
      end
    end
  endtask

  ////////////////////////////////////////////////////////////
  // sink and reference head
  ////////////////////////////////////////////////////////////

  initial begin : sink_driver
    logic hs;
    hs = 1'b0;
    output_axis_tready = 1'b0;
    forever begin
      @(posedge output_clk);
      #5;
      if (hs) begin
        void'(ref_q.pop_front()); // beat taken at the edge just passed.
      end
      output_axis_tready = !sink_stall && ($urandom_range(0, 3) != 0);
      hs = output_axis_tvalid && output_axis_tready;
    end
  end

  always @(negedge output_clk) begin
    exp_count = ref_q.size();
    if (ref_q.size() != 0) begin
      exp_beat = ref_q[0];
    end
  end

  ////////////////////////////////////////////////////////////
  // checks
  ////////////////////////////////////////////////////////////

  reset_ready_low: assert property (@(posedge input_clk)
    output_rst_sync3 |-> !input_axis_tready)
    else report_mismatch("input tready high during reset");

  reset_valid_low: assert property (@(posedge output_clk)
    output_rst_sync3 |=> !output_axis_tvalid)
    else report_mismatch("output tvalid high during reset");

  reset_stats_zero: assert property (@(posedge output_clk)
    output_rst_sync3 |=> frame_count == '0 && bad_frame_count == '0 && last_frame_len == '0)
    else report_mismatch("frame statistics not zero after reset");

  beat_order: assert property (@(posedge output_clk) disable iff (output_rst_sync3)
    output_axis_tvalid && output_axis_tready |->
      exp_count != 0 &&
      {output_axis_tlast, output_axis_tuser, output_axis_tdata} == exp_beat)
    else report_mismatch("output beat differs from the reference queue head");

  beat_hold: assert property (@(posedge output_clk) disable iff (output_rst_sync3)
    output_axis_tvalid && !output_axis_tready |=>
      output_axis_tvalid && $stable(output_axis_tdata) &&
      $stable(output_axis_tlast) && $stable(output_axis_tuser))
    else report_mismatch("output beat changed under back-pressure");

  // memory entries plus the one beat parked in the output register.
  fill_level: assert property (@(posedge input_clk)
    fill_check |-> fill_count == FIFO_DEPTH + 1)
    else report_mismatch("wrong number of beats accepted before full");

  final_length: assert property (@(posedge output_clk) disable iff (output_rst_sync3)
    output_axis_tvalid && output_axis_tready && output_axis_tlast &&
      final_sent && exp_count == 1 |=> last_frame_len == final_len)
    else report_mismatch("last frame length wrong");

  // nothing may be left waiting at the output once every sent beat has left.
  frame_stats: assert property (@(posedge output_clk)
    stats_check |->
      frame_count == frames_sent && bad_frame_count == bad_sent && !output_axis_tvalid)
    else report_mismatch("frame counters disagree with frames sent or extra beat left");

  ////////////////////////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////////////////////////

  initial begin
    int   len;
    logic bad;
    void'($urandom(48));
    output_rst_sync3  = 1'b1;
    input_axis_tdata  = '0;
    input_axis_tvalid = 1'b0;
    input_axis_tlast  = 1'b0;
    input_axis_tuser  = 1'b0;
    repeat (8) @(posedge output_clk);
    #5;
    output_rst_sync3 = 1'b0;

    // fill against a stalled sink, then release it.
    @(posedge input_clk);
    #5;
    fill_buffer();
    fill_check = 1'b1;
    @(posedge input_clk);
    #5;
    fill_check = 1'b0;
    sink_stall = 1'b0;
    wait_accept(); // the beat left waiting at the stall.
    send_beat(DATA_WIDTH'($urandom), 1'b1, 1'b0);
    frames_sent = frames_sent + 1'b1;
    wait_drain();

    for (int f = 0; f < NUM_FRAMES; f++) begin
      len = $urandom_range(1, 9);
      bad = 1'($urandom_range(0, 1));
      send_frame(len, bad);
      final_len = LEN_WIDTH'(len);
    end
    final_sent = 1'b1;
    wait_drain();

    repeat (2) @(posedge output_clk);
    #5;
    stats_check = 1'b1;
    @(posedge output_clk);
    #5;
    stats_check = 1'b0;
    $display("Test OK");
    $finish;
  end

endmodule

/* axis_cdc_link.f */
logic/fifo_geom_pkg.sv
logic/axis_format_pkg.sv
logic/cdc_reset_bridge.sv
logic/axis_async_fifo.sv
logic/axis_frame_monitor.sv
logic/axis_cdc_link.sv
tests/axis_cdc_link_tb.sv

/* Makefile */
# Verilator build and run for the CDC stream link.

VERILATOR ?= verilator
TOP       ?= axis_cdc_link_tb
FILELIST  ?= axis_cdc_link.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -j 0

SOURCES := $(filter-out +%,$(shell cat $(FILELIST)))
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# rebuilt only when a source or the file list changes.
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx "Test OK" $(LOG) || { echo "simulation did not pass, see $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
